//--- Bender.yml
package:
  name: udp_rx

sources:
  - hdl/udp_rx_pkg.sv
  - hdl/udp_hdr_regs.sv
  - hdl/udp_rx_ctrl.sv
  - hdl/udp_payload_skid.sv
  - hdl/udp_rx_top.sv
  - target: simulation
    files:
      - sim/udp_rx_tb.sv

//--- all.f
hdl/udp_rx_pkg.sv
hdl/udp_hdr_regs.sv
hdl/udp_rx_ctrl.sv
hdl/udp_payload_skid.sv
hdl/udp_rx_top.sv
sim/udp_rx_tb.sv

//--- hdl/udp_hdr_regs.sv
// IP and UDP header field registers with the header output handshake
`timescale 1ns/10ps

module udp_hdr_regs (
  input  logic                  clk,
  input  logic                  rst,

  // capture strobes from the controller
  input  logic                  store_ip_hdr,
  input  logic                  store_udp_hdr,

  // incoming IP fields and first payload beat
  input  udp_rx_pkg::proto_t    s_ip_protocol,
  input  udp_rx_pkg::len_t      s_ip_length,
  input  udp_rx_pkg::ip_addr_t  s_ip_source_ip,
  input  udp_rx_pkg::ip_addr_t  s_ip_dest_ip,
  input  udp_rx_pkg::data_t     hdr_word,

  // header output
  output logic                  m_udp_hdr_valid,
  input  logic                  m_udp_hdr_ready,
  output udp_rx_pkg::proto_t    m_ip_protocol,
  output udp_rx_pkg::len_t      m_ip_length,
  output udp_rx_pkg::ip_addr_t  m_ip_source_ip,
  output udp_rx_pkg::ip_addr_t  m_ip_dest_ip,
  output udp_rx_pkg::port_t     m_udp_source_port,
  output udp_rx_pkg::port_t     m_udp_dest_port,
  output udp_rx_pkg::port_t     m_udp_length,
  output udp_rx_pkg::port_t     m_udp_checksum,

  output logic                  hdr_pending
);

  logic hdr_valid_reg;

  assign m_udp_hdr_valid = hdr_valid_reg;
  // controller holds off the next IP header while this is set
  assign hdr_pending = hdr_valid_reg;

  always_ff @(posedge clk) begin
    if (rst) begin
      hdr_valid_reg <= 1'b0;
    end else if (store_udp_hdr) begin
      hdr_valid_reg <= 1'b1;
    end else if (m_udp_hdr_ready) begin
      hdr_valid_reg <= 1'b0;
    end
  end

  // IP fields taken with the IP header transfer
  always_ff @(posedge clk) begin
    if (store_ip_hdr) begin
      m_ip_protocol  <= s_ip_protocol;
      m_ip_length    <= s_ip_length;
      m_ip_source_ip <= s_ip_source_ip;
      m_ip_dest_ip   <= s_ip_dest_ip;
    end
  end

  // UDP fields with the lower byte lane as the high byte on the wire
  always_ff @(posedge clk) begin
    if (store_udp_hdr) begin
      m_udp_source_port <= {hdr_word[7:0], hdr_word[15:8]};
      m_udp_dest_port   <= {hdr_word[23:16], hdr_word[31:24]};
      m_udp_length      <= {hdr_word[39:32], hdr_word[47:40]};
      m_udp_checksum    <= {hdr_word[55:48], hdr_word[63:56]};
    end
  end

endmodule

//--- hdl/udp_payload_skid.sv
// two-entry registered output buffer with early ready for the payload stream
`timescale 1ns/10ps

module udp_payload_skid #(
  parameter int PAYLOAD_WIDTH = 8
) (
  input  logic                     clk,
  input  logic                     rst,

  input  logic [PAYLOAD_WIDTH-1:0] in_payload,
  input  logic                     in_valid,
  output logic                     in_ready_early,

  output logic [PAYLOAD_WIDTH-1:0] out_payload,
  output logic                     out_valid,
  input  logic                     out_ready
);

  logic [PAYLOAD_WIDTH-1:0] out_payload_reg;
  logic [PAYLOAD_WIDTH-1:0] temp_payload_reg;
  logic                     out_valid_reg, out_valid_next;
  logic                     temp_valid_reg, temp_valid_next;
  logic                     in_ready_reg;
  logic                     store_in_to_out;
  logic                     store_in_to_temp;
  logic                     store_temp_to_out;

  assign out_payload = out_payload_reg;
  assign out_valid   = out_valid_reg;

  // room next cycle if the sink takes a word or nothing is held
  assign in_ready_early = out_ready || (!temp_valid_reg && !out_valid_reg);

  always_comb begin
    out_valid_next    = out_valid_reg;
    temp_valid_next   = temp_valid_reg;
    store_in_to_out   = 1'b0;
    store_in_to_temp  = 1'b0;
    store_temp_to_out = 1'b0;

    if (in_ready_reg) begin
      if (out_ready || !out_valid_reg) begin
        out_valid_next  = in_valid;
        store_in_to_out = 1'b1;
      end else begin
        // park the word while the output is stalled
        temp_valid_next  = in_valid;
        store_in_to_temp = 1'b1;
      end
    end else if (out_ready) begin
      out_valid_next    = temp_valid_reg;
      temp_valid_next   = 1'b0;
      store_temp_to_out = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_reg  <= 1'b0;
      temp_valid_reg <= 1'b0;
      in_ready_reg   <= 1'b0;
    end else begin
      out_valid_reg  <= out_valid_next;
      temp_valid_reg <= temp_valid_next;
      in_ready_reg   <= in_ready_early;
    end
  end

  always_ff @(posedge clk) begin
    if (store_in_to_out) begin
      out_payload_reg <= in_payload;
    end else if (store_temp_to_out) begin
      out_payload_reg <= temp_payload_reg;
    end
    if (store_in_to_temp) begin
      temp_payload_reg <= in_payload;
    end
  end

endmodule

//--- hdl/udp_rx_ctrl.sv
// frame FSM with payload byte counting, trimming to IP length and error pulses
`timescale 1ns/10ps

module udp_rx_ctrl (
  input  logic                clk,
  input  logic                rst,

  // IP header handshake
  input  logic                s_ip_hdr_valid,
  output logic                s_ip_hdr_ready,
  input  udp_rx_pkg::len_t    s_ip_length,

  // IP payload stream
  input  udp_rx_pkg::data_t   s_payload_tdata,
  input  udp_rx_pkg::keep_t   s_payload_tkeep,
  input  logic                s_payload_tvalid,
  output logic                s_payload_tready,
  input  logic                s_payload_tlast,
  input  logic                s_payload_tuser,

  // header register strobes
  output logic                store_ip_hdr,
  output logic                store_udp_hdr,
  input  logic                hdr_pending,

  // skid buffer input side
  output udp_rx_pkg::data_t   in_data,
  output udp_rx_pkg::keep_t   in_keep,
  output logic                in_last,
  output logic                in_user,
  output logic                in_valid,
  input  logic                in_ready_early,

  output logic                error_header_early_termination,
  output logic                error_payload_early_termination
);

  // IP plus UDP header bytes not counted as payload
  localparam udp_rx_pkg::len_t hdr_total =
    udp_rx_pkg::len_t'(udp_rx_pkg::ip_hdr_bytes + udp_rx_pkg::udp_hdr_bytes);

  udp_rx_pkg::state_t state_reg, state_next;
  udp_rx_pkg::len_t   count_reg, count_next;
  udp_rx_pkg::len_t   beat_bytes;
  logic               hdr_ready_next;
  logic               tready_next;
  logic               err_hdr_next;
  logic               err_pay_next;
  logic               beat_in;

  assign beat_in    = s_payload_tvalid && s_payload_tready;
  assign beat_bytes = udp_rx_pkg::keep_count(s_payload_tkeep);

  // payload lanes past the counted end are cleared
  assign in_data = s_payload_tdata;
  assign in_keep = s_payload_tkeep & udp_rx_pkg::count_keep(count_reg);

  always_comb begin
    state_next     = state_reg;
    count_next     = count_reg;
    hdr_ready_next = 1'b0;
    tready_next    = 1'b0;
    store_ip_hdr   = 1'b0;
    store_udp_hdr  = 1'b0;
    err_hdr_next   = 1'b0;
    err_pay_next   = 1'b0;
    in_valid       = 1'b0;
    in_last        = 1'b0;
    in_user        = s_payload_tuser;

    case (state_reg)
      udp_rx_pkg::st_idle: begin
        hdr_ready_next = !hdr_pending;
        if (s_ip_hdr_valid && s_ip_hdr_ready) begin
          store_ip_hdr   = 1'b1;
          hdr_ready_next = 1'b0;
          tready_next    = 1'b1;
          // short IP length means no payload at all
          count_next     = (s_ip_length > hdr_total) ? s_ip_length - hdr_total : '0;
          state_next     = udp_rx_pkg::st_header;
        end
      end

      udp_rx_pkg::st_header: begin
        tready_next = 1'b1;
        if (beat_in) begin
          if (s_payload_tlast && count_reg != '0) begin
            err_hdr_next = 1'b1;
            tready_next  = 1'b0;
            state_next   = udp_rx_pkg::st_idle;
          end else begin
            store_udp_hdr = 1'b1;
            if (count_reg == '0) begin
              tready_next = !s_payload_tlast;
              state_next  = s_payload_tlast ? udp_rx_pkg::st_idle : udp_rx_pkg::st_drain;
            end else begin
              tready_next = in_ready_early;
              state_next  = udp_rx_pkg::st_payload;
            end
          end
        end
      end

      udp_rx_pkg::st_payload: begin
        tready_next = in_ready_early;
        if (beat_in) begin
          in_valid = 1'b1;
          if (beat_bytes >= count_reg) begin
            // counted end reached so any padding is dropped in drain
            in_last     = 1'b1;
            count_next  = '0;
            tready_next = !s_payload_tlast;
            state_next  = s_payload_tlast ? udp_rx_pkg::st_idle : udp_rx_pkg::st_drain;
          end else if (s_payload_tlast) begin
            in_last      = 1'b1;
            in_user      = 1'b1;
            err_pay_next = 1'b1;
            tready_next  = 1'b0;
            state_next   = udp_rx_pkg::st_idle;
          end else begin
            count_next = count_reg - beat_bytes;
          end
        end
      end

      udp_rx_pkg::st_drain: begin
        tready_next = 1'b1;
        if (beat_in && s_payload_tlast) begin
          tready_next = 1'b0;
          state_next  = udp_rx_pkg::st_idle;
        end
      end

      default: begin
        state_next = udp_rx_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_reg                       <= udp_rx_pkg::st_idle;
      count_reg                       <= '0;
      s_ip_hdr_ready                  <= 1'b0;
      s_payload_tready                <= 1'b0;
      error_header_early_termination  <= 1'b0;
      error_payload_early_termination <= 1'b0;
    end else begin
      state_reg                       <= state_next;
      count_reg                       <= count_next;
      s_ip_hdr_ready                  <= hdr_ready_next;
      s_payload_tready                <= tready_next;
      error_header_early_termination  <= err_hdr_next;
      error_payload_early_termination <= err_pay_next;
    end
  end

endmodule

//--- hdl/udp_rx_pkg.sv
// shared widths, field types, header sizes, controller states and keep/count helpers
package udp_rx_pkg;

  // datapath geometry
  localparam int data_bytes = 8;

  typedef logic [data_bytes*8-1:0] data_t;
  typedef logic [data_bytes-1:0]   keep_t;

  // header field types
  typedef logic [15:0] port_t;
  typedef logic [15:0] len_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [7:0]  proto_t;

  // no IP options expected
  localparam int ip_hdr_bytes  = 20;
  localparam int udp_hdr_bytes = 8;

  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_header  = 2'd1,
    st_payload = 2'd2,
    st_drain   = 2'd3
  } state_t;

  // byte count of a low-aligned keep
  function automatic len_t keep_count(input keep_t keep);
    len_t n;
    n = '0;
    for (int i = 0; i < data_bytes; i++) begin
      n = n + len_t'(keep[i]);
    end
    return n;
  endfunction

  // low n lanes enabled, saturating at a full beat
  function automatic keep_t count_keep(input len_t n);
    keep_t k;
    for (int i = 0; i < data_bytes; i++) begin
      k[i] = (n > len_t'(i));
    end
    return k;
  endfunction

endpackage

//--- hdl/udp_rx_top.sv
// UDP receive top level with controller, header registers and payload skid buffer
`timescale 1ns/10ps

module udp_rx_top (
  input  logic                  clk,
  input  logic                  rst,

  // IP frame input
  input  logic                  s_ip_hdr_valid,
  output logic                  s_ip_hdr_ready,
  input  udp_rx_pkg::proto_t    s_ip_protocol,
  input  udp_rx_pkg::len_t      s_ip_length,
  input  udp_rx_pkg::ip_addr_t  s_ip_source_ip,
  input  udp_rx_pkg::ip_addr_t  s_ip_dest_ip,
  input  udp_rx_pkg::data_t     s_payload_tdata,
  input  udp_rx_pkg::keep_t     s_payload_tkeep,
  input  logic                  s_payload_tvalid,
  output logic                  s_payload_tready,
  input  logic                  s_payload_tlast,
  input  logic                  s_payload_tuser,

  // UDP frame output
  output logic                  m_udp_hdr_valid,
  input  logic                  m_udp_hdr_ready,
  output udp_rx_pkg::proto_t    m_ip_protocol,
  output udp_rx_pkg::len_t      m_ip_length,
  output udp_rx_pkg::ip_addr_t  m_ip_source_ip,
  output udp_rx_pkg::ip_addr_t  m_ip_dest_ip,
  output udp_rx_pkg::port_t     m_udp_source_port,
  output udp_rx_pkg::port_t     m_udp_dest_port,
  output udp_rx_pkg::port_t     m_udp_length,
  output udp_rx_pkg::port_t     m_udp_checksum,
  output udp_rx_pkg::data_t     m_payload_tdata,
  output udp_rx_pkg::keep_t     m_payload_tkeep,
  output logic                  m_payload_tvalid,
  input  logic                  m_payload_tready,
  output logic                  m_payload_tlast,
  output logic                  m_payload_tuser,

  // one-cycle status pulses
  output logic                  error_header_early_termination,
  output logic                  error_payload_early_termination
);

  // data, keep, last and user bundled through the buffer
  localparam int PAYLOAD_WIDTH =
    $bits(udp_rx_pkg::data_t) + $bits(udp_rx_pkg::keep_t) + 2;

  logic                     store_ip_hdr;
  logic                     store_udp_hdr;
  logic                     hdr_pending;
  udp_rx_pkg::data_t        in_data;
  udp_rx_pkg::keep_t        in_keep;
  logic                     in_last;
  logic                     in_user;
  logic                     in_valid;
  logic                     in_ready_early;
  logic [PAYLOAD_WIDTH-1:0] skid_in;
  logic [PAYLOAD_WIDTH-1:0] skid_out;

  assign skid_in = {in_data, in_keep, in_last, in_user};
  assign {m_payload_tdata, m_payload_tkeep, m_payload_tlast, m_payload_tuser} = skid_out;

  udp_rx_ctrl u_ctrl (
    .clk                             (clk),
    .rst                             (rst),
    .s_ip_hdr_valid                  (s_ip_hdr_valid),
    .s_ip_hdr_ready                  (s_ip_hdr_ready),
    .s_ip_length                     (s_ip_length),
    .s_payload_tdata                 (s_payload_tdata),
    .s_payload_tkeep                 (s_payload_tkeep),
    .s_payload_tvalid                (s_payload_tvalid),
    .s_payload_tready                (s_payload_tready),
    .s_payload_tlast                 (s_payload_tlast),
    .s_payload_tuser                 (s_payload_tuser),
    .store_ip_hdr                    (store_ip_hdr),
    .store_udp_hdr                   (store_udp_hdr),
    .hdr_pending                     (hdr_pending),
    .in_data                         (in_data),
    .in_keep                         (in_keep),
    .in_last                         (in_last),
    .in_user                         (in_user),
    .in_valid                        (in_valid),
    .in_ready_early                  (in_ready_early),
    .error_header_early_termination  (error_header_early_termination),
    .error_payload_early_termination (error_payload_early_termination)
  );

  // header word is the first payload beat
  udp_hdr_regs u_hdr (
    .clk               (clk),
    .rst               (rst),
    .store_ip_hdr      (store_ip_hdr),
    .store_udp_hdr     (store_udp_hdr),
    .s_ip_protocol     (s_ip_protocol),
    .s_ip_length       (s_ip_length),
    .s_ip_source_ip    (s_ip_source_ip),
    .s_ip_dest_ip      (s_ip_dest_ip),
    .hdr_word          (s_payload_tdata),
    .m_udp_hdr_valid   (m_udp_hdr_valid),
    .m_udp_hdr_ready   (m_udp_hdr_ready),
    .m_ip_protocol     (m_ip_protocol),
    .m_ip_length       (m_ip_length),
    .m_ip_source_ip    (m_ip_source_ip),
    .m_ip_dest_ip      (m_ip_dest_ip),
    .m_udp_source_port (m_udp_source_port),
    .m_udp_dest_port   (m_udp_dest_port),
    .m_udp_length      (m_udp_length),
    .m_udp_checksum    (m_udp_checksum),
    .hdr_pending       (hdr_pending)
  );

  udp_payload_skid #(
    .PAYLOAD_WIDTH (PAYLOAD_WIDTH)
  ) u_skid (
    .clk            (clk),
    .rst            (rst),
    .in_payload     (skid_in),
    .in_valid       (in_valid),
    .in_ready_early (in_ready_early),
    .out_payload    (skid_out),
    .out_valid      (m_payload_tvalid),
    .out_ready      (m_payload_tready)
  );

endmodule

//--- sim/udp_rx_tb.sv
// directed testbench for udp_rx_top with clock, reset, LFSR stimulus, compare tasks and tests
`timescale 1ns/10ps

module udp_rx_tb;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 s_ip_hdr_valid;
  logic                 s_ip_hdr_ready;
  udp_rx_pkg::proto_t   s_ip_protocol;
  udp_rx_pkg::len_t     s_ip_length;
  udp_rx_pkg::ip_addr_t s_ip_source_ip;
  udp_rx_pkg::ip_addr_t s_ip_dest_ip;
  udp_rx_pkg::data_t    s_payload_tdata;
  udp_rx_pkg::keep_t    s_payload_tkeep;
  logic                 s_payload_tvalid;
  logic                 s_payload_tready;
  logic                 s_payload_tlast;
  logic                 s_payload_tuser;
  logic                 m_udp_hdr_valid;
  logic                 m_udp_hdr_ready;
  udp_rx_pkg::proto_t   m_ip_protocol;
  udp_rx_pkg::len_t     m_ip_length;
  udp_rx_pkg::ip_addr_t m_ip_source_ip;
  udp_rx_pkg::ip_addr_t m_ip_dest_ip;
  udp_rx_pkg::port_t    m_udp_source_port;
  udp_rx_pkg::port_t    m_udp_dest_port;
  udp_rx_pkg::port_t    m_udp_length;
  udp_rx_pkg::port_t    m_udp_checksum;
  udp_rx_pkg::data_t    m_payload_tdata;
  udp_rx_pkg::keep_t    m_payload_tkeep;
  logic                 m_payload_tvalid;
  logic                 m_payload_tready;
  logic                 m_payload_tlast;
  logic                 m_payload_tuser;
  logic                 error_header_early_termination;
  logic                 error_payload_early_termination;

  logic [31:0] lfsr;
  int          errors;
  int          tests_run;
  int          tests_failed;

  udp_rx_top u_udp_rx_top (.*);

  always #4 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  task automatic port_compare(input string name, input udp_rx_pkg::port_t got,
                              input udp_rx_pkg::port_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic addr_compare(input string name, input udp_rx_pkg::ip_addr_t got,
                              input udp_rx_pkg::ip_addr_t exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // data compared only in the enabled lanes
  task automatic beat_compare(input udp_rx_pkg::data_t got_d, input udp_rx_pkg::keep_t got_k,
                              input udp_rx_pkg::data_t exp_d, input udp_rx_pkg::keep_t exp_k);
    udp_rx_pkg::data_t mask;
    for (int l = 0; l < udp_rx_pkg::data_bytes; l++) begin
      mask[l*8 +: 8] = {8{exp_k[l]}};
    end
    if (got_k !== exp_k) begin
      $display("FAIL m_payload_tkeep got %h expected %h", got_k, exp_k);
      errors++;
    end
    if ((got_d & mask) !== exp_d) begin
      $display("FAIL m_payload_tdata got %h expected %h", got_d & mask, exp_d);
      errors++;
    end
  endtask

  task automatic flag_compare(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // sends one frame and checks header, payload and error pulses against the model
  task automatic run_frame(input udp_rx_pkg::len_t ip_len, input int stream_bytes,
                           input bit pay_bp, input bit hdr_bp);
    udp_rx_pkg::proto_t   proto;
    udp_rx_pkg::ip_addr_t src_ip;
    udp_rx_pkg::ip_addr_t dst_ip;
    logic [7:0]           stream[$];
    udp_rx_pkg::data_t    in_d[$];
    udp_rx_pkg::keep_t    in_k[$];
    udp_rx_pkg::data_t    exp_d[$];
    udp_rx_pkg::keep_t    exp_k[$];
    udp_rx_pkg::data_t    d;
    udp_rx_pkg::keep_t    k;
    int                   count, body, out_bytes, n_in, nb, bi, ob;
    int                   hdr_out, err_h, err_p, tail, cyc;
    bit                   hdr_err, pay_err, ip_sent, hdr_wait, is_last;
    proto  = udp_rx_pkg::proto_t'(next_bits(8));
    src_ip = next_bits(32);
    dst_ip = next_bits(32);
    for (int i = 0; i < stream_bytes; i++) begin
      stream.push_back(8'(next_bits(8)));
    end
    n_in = (stream_bytes + 7) / 8;
    for (int b = 0; b < n_in; b++) begin
      d = '0;
      k = '0;
      for (int l = 0; l < 8; l++) begin
        if (b * 8 + l < stream_bytes) begin
          d[l*8 +: 8] = stream[b*8+l];
          k[l] = 1'b1;
        end
      end
      in_d.push_back(d);
      in_k.push_back(k);
    end
    // payload length implied by the IP total length
    count = ip_len - (udp_rx_pkg::ip_hdr_bytes + udp_rx_pkg::udp_hdr_bytes);
    if (count < 0) count = 0;
    body      = stream_bytes - 8;
    hdr_err   = (n_in == 1) && (count != 0);
    pay_err   = !hdr_err && (count > body);
    out_bytes = hdr_err ? 0 : ((count < body) ? count : body);
    nb        = (out_bytes + 7) / 8;
    for (int j = 0; j < nb; j++) begin
      d = '0;
      k = '0;
      for (int l = 0; l < 8; l++) begin
        if (j * 8 + l < out_bytes) begin
          d[l*8 +: 8] = stream[8+j*8+l];
          k[l] = 1'b1;
        end
      end
      exp_d.push_back(d);
      exp_k.push_back(k);
    end

    s_ip_hdr_valid   <= 1'b1;
    s_ip_protocol    <= proto;
    s_ip_length      <= ip_len;
    s_ip_source_ip   <= src_ip;
    s_ip_dest_ip     <= dst_ip;
    s_payload_tvalid <= 1'b1;
    s_payload_tdata  <= in_d[0];
    s_payload_tkeep  <= in_k[0];
    s_payload_tlast  <= (n_in == 1);
    s_payload_tuser  <= 1'b0;
    ip_sent  = 0;
    hdr_wait = 0;
    bi = 0;
    ob = 0;
    hdr_out = 0;
    err_h = 0;
    err_p = 0;
    tail = 0;
    cyc = 0;
    while (tail < 4) begin
      @(posedge clk);
      cyc++;
      if (s_ip_hdr_valid && s_ip_hdr_ready) begin
        ip_sent = 1;
        s_ip_hdr_valid <= 1'b0;
      end
      if (s_payload_tvalid && s_payload_tready) begin
        bi++;
        if (bi < n_in) begin
          s_payload_tdata <= in_d[bi];
          s_payload_tkeep <= in_k[bi];
          s_payload_tlast <= (bi == n_in - 1);
        end else begin
          s_payload_tvalid <= 1'b0;
          s_payload_tlast  <= 1'b0;
        end
      end
      // a header not yet taken must stay valid
      if (hdr_wait) flag_compare("m_udp_hdr_valid", m_udp_hdr_valid, 1'b1);
      hdr_wait = m_udp_hdr_valid && !m_udp_hdr_ready;
      if (m_udp_hdr_valid && m_udp_hdr_ready) begin
        hdr_out++;
        port_compare("m_ip_protocol", udp_rx_pkg::port_t'(m_ip_protocol),
                     udp_rx_pkg::port_t'(proto));
        port_compare("m_ip_length", m_ip_length, ip_len);
        addr_compare("m_ip_source_ip", m_ip_source_ip, src_ip);
        addr_compare("m_ip_dest_ip", m_ip_dest_ip, dst_ip);
        port_compare("m_udp_source_port", m_udp_source_port, {stream[0], stream[1]});
        port_compare("m_udp_dest_port", m_udp_dest_port, {stream[2], stream[3]});
        port_compare("m_udp_length", m_udp_length, {stream[4], stream[5]});
        port_compare("m_udp_checksum", m_udp_checksum, {stream[6], stream[7]});
      end
      if (m_payload_tvalid && m_payload_tready) begin
        if (ob < nb) begin
          is_last = (ob == nb - 1);
          beat_compare(m_payload_tdata, m_payload_tkeep, exp_d[ob], exp_k[ob]);
          flag_compare("m_payload_tlast", m_payload_tlast, is_last);
          flag_compare("m_payload_tuser", m_payload_tuser, is_last && pay_err);
        end else begin
          $display("payload beat %0d arrived after the expected end of the frame", ob);
          errors++;
        end
        ob++;
      end
      err_h += error_header_early_termination;
      err_p += error_payload_early_termination;
      m_payload_tready <= pay_bp ? (next_bits(1) != 0) : 1'b1;
      m_udp_hdr_ready  <= hdr_bp ? (next_bits(1) != 0) : 1'b1;
      if (ip_sent && bi >= n_in && ob >= nb && hdr_out >= (hdr_err ? 0 : 1)) tail++;
      if (cyc > 2000) begin
        $display("timeout, the frame did not complete within 2000 cycles");
        errors++;
        tail = 4;
      end
    end
    s_ip_hdr_valid   <= 1'b0;
    s_payload_tvalid <= 1'b0;
    m_payload_tready <= 1'b1;
    m_udp_hdr_ready  <= 1'b1;
    flag_compare("m_udp_hdr_valid", hdr_out != 0, !hdr_err);
    flag_compare("error_header_early_termination", err_h != 0, hdr_err);
    flag_compare("error_payload_early_termination", err_p != 0, pay_err);
    if (hdr_out > 1 || err_h > 1 || err_p > 1) begin
      $display("header output or error pulse was seen more than once in one frame");
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d check(s) failed", name, errors - errors_before);
    end
  endtask

  task automatic header_fields_test();
    int e0;
    e0 = errors;
    run_frame(16'd44, 24, 1'b0, 1'b1);
    report_test("header extraction", e0);
  endtask

  task automatic exact_length_test();
    int e0;
    e0 = errors;
    run_frame(16'd49, 29, 1'b0, 1'b0);
    report_test("exact length payload", e0);
  endtask

  // padded frame followed by a clean frame
  task automatic trim_padding_test();
    int e0;
    e0 = errors;
    run_frame(16'd41, 35, 1'b0, 1'b0);
    run_frame(16'd36, 16, 1'b0, 1'b0);
    report_test("trimming of padding", e0);
  endtask

  task automatic payload_early_end_test();
    int e0;
    e0 = errors;
    run_frame(16'd68, 27, 1'b0, 1'b0);
    report_test("payload early termination", e0);
  endtask

  task automatic header_early_end_test();
    int e0;
    e0 = errors;
    run_frame(16'd60, 8, 1'b0, 1'b0);
    report_test("header early termination", e0);
  endtask

  task automatic back_pressure_test();
    int e0;
    e0 = errors;
    run_frame(16'd65, 45, 1'b1, 1'b1);
    run_frame(16'd58, 43, 1'b1, 1'b1);
    report_test("back-pressure", e0);
  endtask

  initial begin
    lfsr             = 32'h7f36;
    errors           = 0;
    tests_run        = 0;
    tests_failed     = 0;
    rst              = 1'b1;
    s_ip_hdr_valid   = 1'b0;
    s_ip_protocol    = '0;
    s_ip_length      = '0;
    s_ip_source_ip   = '0;
    s_ip_dest_ip     = '0;
    s_payload_tdata  = '0;
    s_payload_tkeep  = '0;
    s_payload_tvalid = 1'b0;
    s_payload_tlast  = 1'b0;
    s_payload_tuser  = 1'b0;
    m_udp_hdr_ready  = 1'b1;
    m_payload_tready = 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    // outputs still show the reset state here
    flag_compare("s_ip_hdr_ready", s_ip_hdr_ready, 1'b0);
    flag_compare("s_payload_tready", s_payload_tready, 1'b0);
    flag_compare("m_udp_hdr_valid", m_udp_hdr_valid, 1'b0);
    flag_compare("m_payload_tvalid", m_payload_tvalid, 1'b0);
    flag_compare("error_header_early_termination", error_header_early_termination, 1'b0);
    flag_compare("error_payload_early_termination", error_payload_early_termination, 1'b0);

    header_fields_test();
    exact_length_test();
    trim_padding_test();
    payload_early_end_test();
    header_early_end_test();
    back_pressure_test();

    $display("%0d tests run, %0d failed, %0d failed checks", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
